/* verilog.f */
+incdir+include
verilog/core_pkg.sv
verilog/core_register_file.sv
verilog/core_id_stage.sv
verilog/core_ex_stage.sv
verilog/core_wb_stage.sv
verilog/core_top.sv
dv/tb_core.sv

/* run.sh */
#!/bin/sh
# Build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_core -f verilog.f -Mdir obj_dir -o sim_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q -F '*** PASSED ***'; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* dv/tb_core.sv */
/*
 * Core testbench: random RV32I ALU stream with a reference register file,
 * retire checks by concurrent assertions, random stalls on both ports
 */
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_core import core_pkg::*; ();

  localparam int          NUM_RANDOM  = 380;
  localparam int          NUM_INSTR   = NUM_RANDOM + 12;
  // Worst random stall stays well below 8 cycles per instruction
  localparam int          CYCLE_LIMIT = NUM_INSTR * 8 + 20;
  localparam logic [31:0] SEED        = 32'h0e3d_0d93;

  logic                     clk_i = 1'b0;
  logic                     rst_i;
  logic                     instr_valid_i;
  logic [`CORE_INSTR_W-1:0] instr_i;
  logic                     instr_ready_o;
  logic                     retire_valid_o;
  logic                     retire_ready_i = 1'b1;
  retire_t                  retire_o;

  // Reference model and scoreboard
  logic [31:0] model_regs [32];
  retire_t     expect_q [$];
  logic [31:0] stim_state;
  logic [31:0] ready_state = SEED ^ 32'h9e37_79b9;
  int          accepted_count = 0;
  int          retired_count = 0;
  int          mismatch_count = 0;
  int          error_count = 0;
  int          cycle_count = 0;

  // Values latched 2 ns before each rising edge
  logic    fire = 1'b0;
  logic    exp_valid = 1'b0;
  logic    got_valid = 1'b0;
  logic    got_ready = 1'b0;
  logic    hold_chk = 1'b0;
  logic    prev_stall = 1'b0;
  logic    first_sample = 1'b0;
  logic    was_running = 1'b0;
  retire_t got_retire;
  retire_t exp_retire;
  retire_t held_retire;
  retire_t prev_retire;

  core_top DUT (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .instr_valid_i  ( instr_valid_i  ),
    .instr_i        ( instr_i        ),
    .instr_ready_o  ( instr_ready_o  ),
    .retire_valid_o ( retire_valid_o ),
    .retire_ready_i ( retire_ready_i ),
    .retire_o       ( retire_o       )
  );

  always #4 clk_i = ~clk_i;

  //////////////////////////////
  // Random numbers and encoding
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_stim();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `CORE_OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, `CORE_OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `CORE_OPC_LUI};
  endfunction

  // Registers x0..x7 only, so dependencies are frequent
  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [31:0] s;
    logic [6:0]  f7;
    logic [6:0]  opc;
    logic [31:0] instr;
    r  = rand_stim();
    s  = rand_stim();
    f7 = (r[12] && (r[11:9] == 3'd0 || r[11:9] == 3'd5)) ? 7'h20 : 7'h00;
    // Junk funct7 now and then
    if (r[15:13] == 3'd0) f7 = s[31:25];
    case (r[18:16])
      3'd0, 3'd1, 3'd2: instr = enc_r(f7, {2'b00, r[8:6]}, {2'b00, r[5:3]}, r[11:9],
                                      {2'b00, r[2:0]});
      3'd3, 3'd4, 3'd5: begin
        if (r[11:9] == 3'd1 || r[11:9] == 3'd5) begin
          instr = enc_i({f7, s[4:0]}, {2'b00, r[5:3]}, r[11:9], {2'b00, r[2:0]});
        end else begin
          instr = enc_i(s[11:0], {2'b00, r[5:3]}, r[11:9], {2'b00, r[2:0]});
        end
      end
      3'd6: instr = enc_u(s[31:12], {2'b00, r[2:0]});
      default: begin
        opc = s[6:0];
        if (opc == `CORE_OPC_OP || opc == `CORE_OPC_OP_IMM || opc == `CORE_OPC_LUI) begin
          opc = 7'h0b;
        end
        instr = {s[31:12], 2'b00, r[2:0], opc};
      end
    endcase
    return instr;
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // RV32I semantics straight from the spec, program order
  task automatic model_accept(input logic [31:0] instr);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        legal;
    retire_t     exp;
    opc   = instr[6:0];
    f3    = instr[14:12];
    f7    = instr[31:25];
    a     = model_regs[instr[19:15]];
    b     = (opc == `CORE_OPC_OP) ? model_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
    res   = 32'h0;
    legal = 1'b1;
    if (opc == `CORE_OPC_LUI) begin
      res = {instr[31:12], 12'h000};
    end else if (opc == `CORE_OPC_OP || opc == `CORE_OPC_OP_IMM) begin
      case (f3)
        3'd0: res = (opc == `CORE_OPC_OP && f7[5]) ? a - b : a + b;
        3'd1: res = a << b[4:0];
        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: res = (a < b) ? 32'd1 : 32'd0;
        3'd4: res = a ^ b;
        // Sign fill only for the arithmetic form
        3'd5: begin
          if (f7[5]) begin
            res = $signed(a) >>> b[4:0];
          end else begin
            res = a >> b[4:0];
          end
        end
        3'd6: res = a | b;
        default: res = a & b;
      endcase
      // funct7 must be zero, or 0x20 for SUB and the arithmetic shift
      if (opc == `CORE_OPC_OP) begin
        legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      end else if (f3 == 3'd1) begin
        legal = (f7 == 7'h00);
      end else if (f3 == 3'd5) begin
        legal = (f7 == 7'h00) || (f7 == 7'h20);
      end
    end else begin
      legal = 1'b0;
    end
    if (legal && instr[11:7] != 5'd0) model_regs[instr[11:7]] = res;
    exp.instr   = instr;
    exp.rd      = instr[11:7];
    exp.wdata   = res;
    exp.we      = legal;
    exp.illegal = !legal;
    expect_q.push_back(exp);
  endtask

  //////////////////////////////
  // Sampling and stimulus
  //////////////////////////////

  // Inputs settle after the falling edge, so sample just before the rising edge
  always @(negedge clk_i) begin
    #2;
    if (rst_i) begin
      for (int i = 0; i < 32; i++) model_regs[i] = 32'h0;
      expect_q.delete();
      fire         = 1'b0;
      hold_chk     = 1'b0;
      prev_stall   = 1'b0;
      was_running  = 1'b0;
      first_sample = 1'b0;
    end else begin
      first_sample = !was_running;
      was_running  = 1'b1;
      hold_chk     = prev_stall;
      held_retire  = prev_retire;
      got_valid    = retire_valid_o;
      got_ready    = instr_ready_o;
      got_retire   = retire_o;
      fire         = retire_valid_o && retire_ready_i;
      exp_valid    = (expect_q.size() > 0);
      exp_retire   = exp_valid ? expect_q[0] : '0;
      if (fire) begin
        retired_count++;
        if (exp_valid) void'(expect_q.pop_front());
      end
      prev_stall  = retire_valid_o && !retire_ready_i;
      prev_retire = retire_o;
      if (instr_valid_i && instr_ready_o) begin
        model_accept(instr_i);
        accepted_count++;
      end
    end
  end

  // Random back-pressure, about one cycle in four
  always @(negedge clk_i) begin
    ready_state    = xorshift32(ready_state);
    retire_ready_i = (ready_state[1:0] != 2'b00);
  end

  // Called right after a falling edge, returns after the accepting edge
  task automatic send_instr(input logic [31:0] instr);
    int target;
    target = accepted_count + 1;
    while (rand_stim() % 4 == 0) begin
      instr_valid_i = 1'b0;
      @(negedge clk_i);
    end
    instr_valid_i = 1'b1;
    instr_i       = instr;
    while (accepted_count < target) @(negedge clk_i);
  endtask

  task automatic report_mismatch(input string name, input logic [95:0] got,
                                 input logic [95:0] exp);
    mismatch_count++;
    $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
  endtask

  task automatic print_summary();
    $display("summary: %0d accepted, %0d retired, %0d mismatches, %0d other errors",
             accepted_count, retired_count, mismatch_count, error_count);
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  assert property (@(posedge clk_i) disable iff (rst_i) first_sample |-> !got_valid && got_ready)
    else begin
      error_count++;
      $display("after reset at %0t the core is not idle and ready", $time);
    end
  assert property (@(posedge clk_i) disable iff (rst_i) fire |-> exp_valid)
    else begin
      error_count++;
      $display("retire at %0t with no instruction in flight", $time);
    end
  assert property (@(posedge clk_i) disable iff (rst_i)
                   fire && exp_valid |-> got_retire.instr == exp_retire.instr)
    else report_mismatch("retire_o.instr", 96'(got_retire.instr), 96'(exp_retire.instr));
  assert property (@(posedge clk_i) disable iff (rst_i)
                   fire && exp_valid |-> got_retire.rd == exp_retire.rd)
    else report_mismatch("retire_o.rd", 96'(got_retire.rd), 96'(exp_retire.rd));
  assert property (@(posedge clk_i) disable iff (rst_i)
                   fire && exp_valid |-> got_retire.we == exp_retire.we)
    else report_mismatch("retire_o.we", 96'(got_retire.we), 96'(exp_retire.we));
  assert property (@(posedge clk_i) disable iff (rst_i)
                   fire && exp_valid |-> got_retire.illegal == exp_retire.illegal)
    else report_mismatch("retire_o.illegal", 96'(got_retire.illegal),
                         96'(exp_retire.illegal));
  // Result only matters when the instruction writes
  assert property (@(posedge clk_i) disable iff (rst_i)
                   fire && exp_valid && exp_retire.we |-> got_retire.wdata == exp_retire.wdata)
    else report_mismatch("retire_o.wdata", 96'(got_retire.wdata), 96'(exp_retire.wdata));
  // Stalled retire must hold
  assert property (@(posedge clk_i) disable iff (rst_i) hold_chk |-> got_valid)
    else begin
      error_count++;
      $display("retire_valid_o dropped at %0t while retire was stalled", $time);
    end
  assert property (@(posedge clk_i) disable iff (rst_i) hold_chk |-> got_retire == held_retire)
    else report_mismatch("retire_o", 96'(got_retire), 96'(held_retire));

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, run did not drain", cycle_count);
      print_summary();
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    stim_state    = SEED;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    // One idle cycle for the reset check
    @(negedge clk_i);
    // Back-to-back bypass, compares, arithmetic shift
    send_instr(enc_i(12'hffb, 5'd0, 3'd0, 5'd1));
    send_instr(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
    send_instr(enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));
    send_instr(enc_i({7'h20, 5'd1}, 5'd1, 3'd5, 5'd4));
    send_instr(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd5));
    send_instr(enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd6));
    // Load encoding into x2, then read x2 back
    send_instr({12'h000, 5'd1, 3'd2, 5'd2, 7'h03});
    send_instr(enc_i(12'h000, 5'd2, 3'd0, 5'd7));
    // Write x0, then read it
    send_instr(enc_i(12'h007, 5'd1, 3'd0, 5'd0));
    send_instr(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd6));
    send_instr(enc_u(20'habcde, 5'd3));
    send_instr(enc_i(12'h7ff, 5'd3, 3'd4, 5'd4));
    for (int i = 0; i < NUM_RANDOM; i++) begin
      send_instr(random_instr());
    end
    instr_valid_i = 1'b0;
    while (retired_count < accepted_count) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
    print_summary();
    if (mismatch_count == 0 && error_count == 0 && expect_q.size() == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog/core_top.sv */
/*
 * Three-stage integer core: ID, EX and WB stages around the register file
 */
`timescale 1ns/1ps
`include "core_defines.svh"

module core_top import core_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,

  // Fetched instruction stream
  input  logic                     instr_valid_i,
  input  logic [`CORE_INSTR_W-1:0] instr_i,
  output logic                     instr_ready_o,

  // Retire port
  output logic                     retire_valid_o,
  input  logic                     retire_ready_i,
  output retire_t                  retire_o
);

  // Pipeline registers
  id_ex_pipe_t id_ex_pipe;
  ex_wb_pipe_t ex_wb_pipe;

  // Ready chain WB -> EX -> ID
  logic        ex_ready;
  logic        wb_ready;

  // Register file reads
  rf_addr_t    rf_raddr_a;
  rf_addr_t    rf_raddr_b;
  rf_data_t    rf_rdata_a;
  rf_data_t    rf_rdata_b;

  // Register file write from WB
  logic        rf_we_wb;
  rf_addr_t    rf_waddr_wb;
  rf_data_t    rf_wdata_wb;

  //////////////////////////////
  // Decode
  //////////////////////////////

  core_id_stage id_stage_i (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .instr_ready_o ( instr_ready_o ),
    .ex_ready_i    ( ex_ready      ),
    // EX/WB also feeds the WB bypass
    .ex_wb_i       ( ex_wb_pipe    ),
    .raddr_a_o     ( rf_raddr_a    ),
    .raddr_b_o     ( rf_raddr_b    ),
    .rdata_a_i     ( rf_rdata_a    ),
    .rdata_b_i     ( rf_rdata_b    ),
    .id_ex_o       ( id_ex_pipe    )
  );

  //////////////////////////////
  // Execute
  //////////////////////////////

  core_ex_stage ex_stage_i (
    .clk_i      ( clk_i      ),
    .rst_i      ( rst_i      ),
    .id_ex_i    ( id_ex_pipe ),
    .ex_ready_o ( ex_ready   ),
    .wb_ready_i ( wb_ready   ),
    .ex_wb_o    ( ex_wb_pipe )
  );

  //////////////////////////////
  // Writeback and retire
  //////////////////////////////

  core_wb_stage wb_stage_i (
    .ex_wb_i        ( ex_wb_pipe     ),
    .wb_ready_o     ( wb_ready       ),
    .retire_valid_o ( retire_valid_o ),
    .retire_ready_i ( retire_ready_i ),
    .retire_o       ( retire_o       ),
    .rf_we_o        ( rf_we_wb       ),
    .rf_waddr_o     ( rf_waddr_wb    ),
    .rf_wdata_o     ( rf_wdata_wb    )
  );

  core_register_file register_file_i (
    .clk_i     ( clk_i       ),
    .rst_i     ( rst_i       ),
    .raddr_a_i ( rf_raddr_a  ),
    .raddr_b_i ( rf_raddr_b  ),
    .rdata_a_o ( rf_rdata_a  ),
    .rdata_b_o ( rf_rdata_b  ),
    .we_i      ( rf_we_wb    ),
    .waddr_i   ( rf_waddr_wb ),
    .wdata_i   ( rf_wdata_wb )
  );

endmodule

/* verilog/core_wb_stage.sv */
/*
 * Writeback stage: retire handshake and register file write
 */
`timescale 1ns/1ps

module core_wb_stage import core_pkg::*; (
  // From execute
  input  ex_wb_pipe_t ex_wb_i,
  output logic        wb_ready_o,

  // Retire port
  output logic        retire_valid_o,
  input  logic        retire_ready_i,
  output retire_t     retire_o,

  // Register file write
  output logic        rf_we_o,
  output rf_addr_t    rf_waddr_o,
  output rf_data_t    rf_wdata_o
);

  logic retire_fire;

  // Entry is held in EX/WB until the retire port takes it
  assign retire_valid_o = ex_wb_i.valid;
  assign retire_fire    = ex_wb_i.valid && retire_ready_i;
  assign wb_ready_o     = !ex_wb_i.valid || retire_ready_i;

  // Retire record, we reports intent even for x0
  assign retire_o.instr   = ex_wb_i.instr;
  assign retire_o.rd      = ex_wb_i.rd;
  assign retire_o.wdata   = ex_wb_i.result;
  assign retire_o.we      = ex_wb_i.rf_we;
  assign retire_o.illegal = ex_wb_i.illegal;

  // Write on the retire edge, skip x0
  assign rf_we_o    = retire_fire && ex_wb_i.rf_we && (ex_wb_i.rd != '0);
  assign rf_waddr_o = ex_wb_i.rd;
  assign rf_wdata_o = ex_wb_i.result;

endmodule

/* verilog/core_ex_stage.sv */
/*
 * Execute stage: single-cycle ALU and the EX/WB pipeline register
 */
`timescale 1ns/1ps

module core_ex_stage import core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,

  // From decode
  input  id_ex_pipe_t id_ex_i,
  output logic        ex_ready_o,

  // To writeback
  input  logic        wb_ready_i,
  output ex_wb_pipe_t ex_wb_o
);

  rf_data_t    alu_result;
  ex_wb_pipe_t ex_wb_q;

  //////////////////////////////
  // ALU
  //////////////////////////////

  // LUI arrives as PASS_B with the U immediate in operand_b
  assign alu_result = alu_compute(id_ex_i.alu_op, id_ex_i.operand_a, id_ex_i.operand_b);

  // Every op finishes in one cycle, so EX is ready whenever WB can take
  assign ex_ready_o = wb_ready_i;

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ex_wb_q.valid <= 1'b0;
    end else if (wb_ready_i) begin
      // Empty ID/EX gives a bubble
      ex_wb_q.valid <= id_ex_i.valid;
      if (id_ex_i.valid) begin
        ex_wb_q.rd      <= id_ex_i.rd;
        ex_wb_q.rf_we   <= id_ex_i.rf_we;
        ex_wb_q.illegal <= id_ex_i.illegal;
        ex_wb_q.result  <= alu_result;
        ex_wb_q.instr   <= id_ex_i.instr;
      end
    end
  end

  assign ex_wb_o = ex_wb_q;

endmodule

/* verilog/core_id_stage.sv */
/*
 * Decode stage: opcode decode, immediates, operand bypass from EX or WB,
 * and the ID/EX pipeline register
 */
`timescale 1ns/1ps
`include "core_defines.svh"

module core_id_stage import core_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,

  // Instruction stream in
  input  logic                     instr_valid_i,
  input  logic [`CORE_INSTR_W-1:0] instr_i,
  output logic                     instr_ready_o,

  // Downstream handshake and bypass source
  input  logic                     ex_ready_i,
  input  ex_wb_pipe_t              ex_wb_i,

  // Register file read
  output rf_addr_t                 raddr_a_o,
  output rf_addr_t                 raddr_b_o,
  input  rf_data_t                 rdata_a_i,
  input  rf_data_t                 rdata_b_i,

  output id_ex_pipe_t              id_ex_o
);

  // Instruction fields
  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  rf_addr_t    rs1;
  rf_addr_t    rs2;
  rf_addr_t    rd;
  rf_data_t    imm_i;
  rf_data_t    imm_u;

  // Decoder outputs
  alu_op_e     dec_alu_op;
  logic        dec_use_imm;
  rf_data_t    dec_imm;
  logic        dec_illegal;

  // Bypass
  fwd_sel_e    fwd_a;
  fwd_sel_e    fwd_b;
  rf_data_t    ex_result;
  rf_data_t    op_a;
  rf_data_t    op_b;

  id_ex_pipe_t id_ex_d;
  id_ex_pipe_t id_ex_q;
  logic        instr_accept;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign rd     = instr_i[11:7];

  // I-type sign extended, U-type upper 20 bits
  assign imm_i  = {{(`CORE_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_u  = {instr_i[31:12], 12'b0};

  //////////////////////////////
  // Decoder
  //////////////////////////////

  always_comb begin
    dec_alu_op  = ALU_ADD;
    dec_use_imm = 1'b0;
    dec_imm     = imm_i;
    dec_illegal = 1'b0;
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  dec_alu_op = ALU_ADD;
            3'b001:  dec_alu_op = ALU_SLL;
            3'b010:  dec_alu_op = ALU_SLT;
            3'b011:  dec_alu_op = ALU_SLTU;
            3'b100:  dec_alu_op = ALU_XOR;
            3'b101:  dec_alu_op = ALU_SRL;
            3'b110:  dec_alu_op = ALU_OR;
            default: dec_alu_op = ALU_AND;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec_alu_op = ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          dec_alu_op = ALU_SRA;
        end else begin
          dec_illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        dec_use_imm = 1'b1;
        case (funct3)
          3'b000: dec_alu_op = ALU_ADD;
          3'b010: dec_alu_op = ALU_SLT;
          3'b011: dec_alu_op = ALU_SLTU;
          3'b100: dec_alu_op = ALU_XOR;
          3'b110: dec_alu_op = ALU_OR;
          3'b111: dec_alu_op = ALU_AND;
          // Shifts need a clean funct7
          3'b001: begin
            dec_alu_op  = ALU_SLL;
            dec_illegal = (funct7 != 7'b0000000);
          end
          default: begin
            dec_alu_op  = (funct7[5]) ? ALU_SRA : ALU_SRL;
            dec_illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end
      OPC_LUI: begin
        dec_alu_op  = ALU_PASS_B;
        dec_use_imm = 1'b1;
        dec_imm     = imm_u;
      end
      default: dec_illegal = 1'b1;
    endcase
  end

  //////////////////////////////
  // Operand bypass
  //////////////////////////////

  // Youngest producer wins, x0 never forwarded
  function automatic fwd_sel_e fwd_select(input rf_addr_t rs, input id_ex_pipe_t ex,
                                          input ex_wb_pipe_t wb);
    fwd_sel_e sel;
    sel = FWD_RF;
    if (ex.valid && ex.rf_we && (ex.rd != '0) && (ex.rd == rs)) begin
      sel = FWD_EX;
    end else if (wb.valid && wb.rf_we && (wb.rd != '0) && (wb.rd == rs)) begin
      sel = FWD_WB;
    end
    return sel;
  endfunction

  assign raddr_a_o = rs1;
  assign raddr_b_o = rs2;

  // Result of the instruction now in EX
  assign ex_result = alu_compute(id_ex_q.alu_op, id_ex_q.operand_a, id_ex_q.operand_b);

  assign fwd_a = fwd_select(rs1, id_ex_q, ex_wb_i);
  assign fwd_b = fwd_select(rs2, id_ex_q, ex_wb_i);

  always_comb begin
    case (fwd_a)
      FWD_EX:  op_a = ex_result;
      FWD_WB:  op_a = ex_wb_i.result;
      default: op_a = rdata_a_i;
    endcase
    case (fwd_b)
      FWD_EX:  op_b = ex_result;
      FWD_WB:  op_b = ex_wb_i.result;
      default: op_b = rdata_b_i;
    endcase
  end

  //////////////////////////////
  // ID/EX register
  //////////////////////////////

  always_comb begin
    id_ex_d.valid     = 1'b1;
    id_ex_d.alu_op    = dec_alu_op;
    id_ex_d.operand_a = op_a;
    id_ex_d.operand_b = dec_use_imm ? dec_imm : op_b;
    id_ex_d.rd        = rd;
    // Illegal encodings never write
    id_ex_d.rf_we     = !dec_illegal;
    id_ex_d.illegal   = dec_illegal;
    id_ex_d.instr     = instr_i;
  end

  // Free slot or EX drains it this cycle
  assign instr_ready_o = !id_ex_q.valid || ex_ready_i;
  assign instr_accept  = instr_valid_i && instr_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      id_ex_q.valid <= 1'b0;
    end else if (instr_accept) begin
      id_ex_q <= id_ex_d;
    end else if (ex_ready_i) begin
      id_ex_q.valid <= 1'b0;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

/* verilog/core_register_file.sv */
/*
 * Integer register file, 2 async read ports and 1 write port, x0 tied to zero
 */
`timescale 1ns/1ps
`include "core_defines.svh"

module core_register_file import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,

  // Read ports, combinational
  input  rf_addr_t raddr_a_i,
  input  rf_addr_t raddr_b_i,
  output rf_data_t rdata_a_o,
  output rf_data_t rdata_b_o,

  // Write port from WB
  input  logic     we_i,
  input  rf_addr_t waddr_i,
  input  rf_data_t wdata_i
);

  // x1..x31 only, x0 has no storage
  rf_data_t regs_q [1:`CORE_NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < `CORE_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Reads of x0 return zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* verilog/core_pkg.sv */
/*
 * Core types: opcode and ALU enums, pipeline payloads, retire record,
 * and the shared ALU function used by EX and by the EX bypass in ID
 */
`include "core_defines.svh"

package core_pkg;

  // Register file address and data
  typedef logic [`CORE_REG_AW-1:0] rf_addr_t;
  typedef logic [`CORE_XLEN-1:0]   rf_data_t;

  // Kept major opcodes
  typedef enum logic [6:0] {
    OPC_OP     = `CORE_OPC_OP,
    OPC_OP_IMM = `CORE_OPC_OP_IMM,
    OPC_LUI    = `CORE_OPC_LUI
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // LUI, immediate straight through
  } alu_op_e;

  // Operand source in decode
  typedef enum logic [1:0] {
    FWD_RF,
    FWD_EX,
    FWD_WB
  } fwd_sel_e;

  //////////////////////////////
  // Pipeline payloads
  //////////////////////////////

  typedef struct packed {
    logic                     valid;
    alu_op_e                  alu_op;
    rf_data_t                 operand_a;
    rf_data_t                 operand_b;
    rf_addr_t                 rd;
    logic                     rf_we;
    logic                     illegal;
    logic [`CORE_INSTR_W-1:0] instr;
  } id_ex_pipe_t;

  typedef struct packed {
    logic                     valid;
    rf_addr_t                 rd;
    logic                     rf_we;
    logic                     illegal;
    rf_data_t                 result;
    logic [`CORE_INSTR_W-1:0] instr;
  } ex_wb_pipe_t;

  // One record per retired instruction
  typedef struct packed {
    logic [`CORE_INSTR_W-1:0] instr;
    rf_addr_t                 rd;
    rf_data_t                 wdata;
    logic                     we;
    logic                     illegal;
  } retire_t;

  // Single-cycle ALU, shift amount from low 5 bits of b
  function automatic rf_data_t alu_compute(input alu_op_e op, input rf_data_t a,
                                           input rf_data_t b);
    logic [4:0] shamt;
    rf_data_t   res;
    shamt = b[4:0];
    case (op)
      ALU_ADD:  res = a + b;
      ALU_SUB:  res = a - b;
      ALU_SLL:  res = a << shamt;
      ALU_SLT:  res = {{(`CORE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: res = {{(`CORE_XLEN-1){1'b0}}, a < b};
      ALU_XOR:  res = a ^ b;
      ALU_SRL:  res = a >> shamt;
      ALU_SRA:  res = rf_data_t'($signed(a) >>> shamt);
      ALU_OR:   res = a | b;
      ALU_AND:  res = a & b;
      default:  res = b;
    endcase
    return res;
  endfunction

endpackage

/* include/core_defines.svh */
/*
 * Core pipeline widths, register count and RV32I major opcodes
 */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// XLEN of the integer datapath
`define CORE_XLEN       32
// Register index width, x0..x31
`define CORE_REG_AW     5
`define CORE_NUM_REGS   32
`define CORE_INSTR_W    32

//////////////////////////////
// Major opcodes, instr[6:0]
//////////////////////////////

`define CORE_OPC_OP     7'h33
`define CORE_OPC_OP_IMM 7'h13
`define CORE_OPC_LUI    7'h37

`endif
